//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module tb_register_manager -Mdir obj_dir
	./obj_dir/Vtb_register_manager | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/addr_translate.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module addr_translate (
  input  wire logic [`REGMAN_ADDR_W-1:0] logical,
  input  wire regman_pkg::seg_cfg_t      seg,
  output logic [`REGMAN_ADDR_W-1:0]      physical
);

  // base chosen by the segment the address falls into
  logic [`REGMAN_ADDR_W-1:0] base;
  logic                      above_unmod;
  logic                      above_code;

  // shared area at the top is never relocated
  assign above_unmod = (logical >= seg.unmod_bound);

  // past code memory means process data
  assign above_code = (logical >= seg.mem1_size);

  always_comb begin
    if (above_unmod) begin
      // absolute address
      base = '0;
    end else if (above_code) begin
      // data segment of the process
      base = seg.base_addr_data;
    end else begin
      // code and register area of the process
      base = seg.base_addr;
    end
  end

  // plain add that wraps at the address width
  assign physical = logical + base;

endmodule

`default_nettype wire

//--- hw/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module bus_sequencer (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire regman_pkg::reg_op_t       op,
  input  wire regman_pkg::reg_sel_t      sel,
  input  wire regman_pkg::seg_cfg_t      seg,
  input  wire logic                      alu_result,
  input  wire logic                      online,
  input  wire logic [`REGMAN_DATA_W-1:0] register_in,
  input  wire logic [`REGMAN_DATA_W-1:0] reg_ptr_in,
  input  wire logic [`REGMAN_DATA_W-1:0] ptr_value,
  input  wire logic [`REGMAN_DATA_W-1:0] save_data,
  input  wire logic [`REGMAN_ADDR_W-1:0] ptr_phys,
  input  wire logic [`REGMAN_ADDR_W-1:0] save_phys,
  input  wire regman_pkg::bus_rsp_t      rsp,
  output regman_pkg::bus_req_t           req,
  output regman_pkg::reg_load_t          load,
  output logic                           next_state,
  output logic [`REGMAN_ADDR_W-1:0]      save_logical
);

  // op decode
  logic is_catch;
  logic is_rd;
  logic is_rd_ptr;
  logic is_wr;
  logic is_bus_op;

  // request / response control
  logic single;
  logic catched;
  logic pending;
  logic read_q_r;
  logic write_q_r;
  logic next_state_r;
  logic issue;
  logic addr_hit;
  logic read_hit;
  logic read_ptr_hit;
  logic write_hit;
  logic catch_fire;

  // outstanding address and write payload
  logic [`REGMAN_ADDR_W-1:0] addr_r;
  logic [`REGMAN_DATA_W-1:0] data_r;
  logic [`REGMAN_ADDR_W-1:0] reg_addr;
  logic [`REGMAN_ADDR_W-1:0] target;

  assign is_catch  = (op == regman_pkg::op_catch);
  assign is_rd     = (op == regman_pkg::op_read);
  assign is_rd_ptr = (op == regman_pkg::op_read_ptr);
  assign is_wr     = (op == regman_pkg::op_write) || (op == regman_pkg::op_write_ptr);
  assign is_bus_op = is_rd || is_rd_ptr || is_wr;

  // read by number skips the segment rule
  assign reg_addr = seg.base_addr +
                    {{(`REGMAN_ADDR_W-`REGMAN_REG_NUM_W){1'b0}}, sel.reg_num};

  // write by number or through the pointer copy
  assign save_logical = (op == regman_pkg::op_write_ptr) ? ptr_value :
                        {{(`REGMAN_ADDR_W-`REGMAN_REG_NUM_W){1'b0}}, sel.reg_num};

  always_comb begin
    if (is_rd) begin
      target = reg_addr;
    end else if (is_rd_ptr) begin
      target = ptr_phys;
    end else begin
      target = save_phys;
    end
  end

  // one request per online period, never while the bus is busy
  assign issue = is_bus_op && online && single && !rsp.busy && !pending;

  // responses only count while busy is up
  assign addr_hit     = pending && rsp.busy && (rsp.addr == addr_r);
  assign read_hit     = is_rd && addr_hit && rsp.read_dn;
  assign read_ptr_hit = is_rd_ptr && addr_hit && rsp.read_dn;
  assign write_hit    = is_wr && addr_hit && rsp.write_dn;

  // capture once per catch op
  assign catch_fire = is_catch && !catched;

  always_ff @(posedge clk) begin
    if (rst) begin
      single       <= 1'b0;
      catched      <= 1'b0;
      pending      <= 1'b0;
      read_q_r     <= 1'b0;
      write_q_r    <= 1'b0;
      next_state_r <= 1'b0;
    end else begin
      // strobes and completion last a single cycle
      read_q_r     <= 1'b0;
      write_q_r    <= 1'b0;
      next_state_r <= 1'b0;
      if (issue) begin
        read_q_r  <= is_rd || is_rd_ptr;
        write_q_r <= is_wr;
        pending   <= 1'b1;
        single    <= 1'b0;
      end else if (read_hit || read_ptr_hit || write_hit) begin
        pending      <= 1'b0;
        next_state_r <= 1'b1;
      end else if (!is_bus_op) begin
        // op dropped, forget any stale request
        pending <= 1'b0;
      end
      // re-arm while offline
      if (!online) begin
        single <= 1'b1;
      end
      // re-arm capture once op moves on
      if (!is_catch) begin
        catched <= 1'b0;
      end else if (catch_fire) begin
        catched <= 1'b1;
      end
    end
  end

  // request payload, held until the matching done
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_r <= target;
      data_r <= save_data;
    end
  end

  // bus quiet when offline or between strobes
  always_comb begin
    req         = '0;
    req.read_q  = online && read_q_r;
    req.write_q = online && write_q_r;
    if (online && (read_q_r || write_q_r)) begin
      req.addr = addr_r;
    end
    if (online && write_q_r) begin
      req.data = data_r;
    end
  end

  // load steering into the value path
  always_comb begin
    load.load_reg      = catch_fire || read_hit || read_ptr_hit;
    load.load_ptr      = (catch_fire && !alu_result) || read_hit;
    load.mark_read     = catch_fire || read_hit;
    load.mark_read_ptr = (catch_fire && !alu_result) || read_ptr_hit;
    if (is_catch) begin
      load.reg_value = alu_result ? register_in : reg_ptr_in;
      load.ptr_value = reg_ptr_in;
    end else begin
      load.reg_value = rsp.data;
      load.ptr_value = rsp.data;
    end
  end

  // catch completes in the same cycle
  assign next_state = next_state_r || is_catch;

endmodule

`default_nettype wire

//--- hw/reg_value_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module reg_value_path (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire regman_pkg::reg_load_t     load,
  input  wire regman_pkg::reg_op_t       op,
  input  wire regman_pkg::reg_sel_t      sel,
  output logic [`REGMAN_DATA_W-1:0]      reg_value,
  output logic [`REGMAN_DATA_W-1:0]      ptr_value,
  output logic [`REGMAN_DATA_W-1:0]      save_data,
  output logic                           is_read,
  output logic                           is_read_ptr
);

  // working copies
  logic [`REGMAN_DATA_W-1:0] reg_q;
  logic [`REGMAN_DATA_W-1:0] ptr_q;

  // sticky status
  logic read_q;
  logic read_ptr_q;

  // save path
  logic                      save_reg_copy;
  logic [`REGMAN_DATA_W-1:0] save_base;

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_q      <= '0;
      ptr_q      <= '0;
      read_q     <= 1'b0;
      read_ptr_q <= 1'b0;
    end else begin
      if (load.load_reg) begin
        reg_q <= load.reg_value;
      end
      if (load.load_ptr) begin
        ptr_q <= load.ptr_value;
      end
      // flags only ever set until the next reset
      if (load.mark_read) begin
        read_q <= 1'b1;
      end
      if (load.mark_read_ptr) begin
        read_ptr_q <= 1'b1;
      end
    end
  end

  // register copy for a plain write or a write through a pointer register
  // and the pointer copy for everything else
  assign save_reg_copy = (!sel.is_ptr && (op == regman_pkg::op_write)) ||
                         (sel.is_ptr && (op == regman_pkg::op_write_ptr));

  assign save_base = save_reg_copy ? reg_q : ptr_q;

  // post increment / decrement
  always_comb begin
    save_data = save_base;
    // write through pointer stores the value as is
    if (op != regman_pkg::op_write_ptr) begin
      case (sel.step)
        regman_pkg::step_inc: save_data = save_base + `REGMAN_DATA_W'(1);
        regman_pkg::step_dec: save_data = save_base - `REGMAN_DATA_W'(1);
        default:              save_data = save_base;
      endcase
    end
  end

  assign reg_value   = reg_q;
  assign ptr_value   = ptr_q;
  assign is_read     = read_q;
  assign is_read_ptr = read_ptr_q;

endmodule

`default_nettype wire

//--- hw/register_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module register_manager (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire regman_pkg::reg_op_t       op,
  input  wire regman_pkg::reg_sel_t      sel,
  input  wire regman_pkg::seg_cfg_t      seg,
  input  wire logic                      alu_result,
  input  wire logic                      online,
  input  wire logic [`REGMAN_DATA_W-1:0] register_in,
  input  wire logic [`REGMAN_DATA_W-1:0] reg_ptr_in,
  input  wire regman_pkg::bus_rsp_t      rsp,
  output regman_pkg::bus_req_t           req,
  output logic [`REGMAN_DATA_W-1:0]      register_out,
  output logic [`REGMAN_DATA_W-1:0]      reg_ptr_out,
  output logic                           is_read,
  output logic                           is_read_ptr,
  output logic                           next_state
);

  regman_pkg::reg_load_t     load;
  logic [`REGMAN_DATA_W-1:0] reg_value;
  logic [`REGMAN_DATA_W-1:0] ptr_value;
  logic [`REGMAN_DATA_W-1:0] save_data;
  logic [`REGMAN_ADDR_W-1:0] ptr_phys;
  logic [`REGMAN_ADDR_W-1:0] save_phys;
  logic [`REGMAN_ADDR_W-1:0] save_logical;

  // request control and load steering
  bus_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .sel          (sel),
    .seg          (seg),
    .alu_result   (alu_result),
    .online       (online),
    .register_in  (register_in),
    .reg_ptr_in   (reg_ptr_in),
    .ptr_value    (ptr_value),
    .save_data    (save_data),
    .ptr_phys     (ptr_phys),
    .save_phys    (save_phys),
    .rsp          (rsp),
    .req          (req),
    .load         (load),
    .next_state   (next_state),
    .save_logical (save_logical)
  );

  // working copies and save value
  reg_value_path u_val (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .op          (op),
    .sel         (sel),
    .reg_value   (reg_value),
    .ptr_value   (ptr_value),
    .save_data   (save_data),
    .is_read     (is_read),
    .is_read_ptr (is_read_ptr)
  );

  // read through pointer
  addr_translate ptr_xlate (
    .logical  (ptr_value),
    .seg      (seg),
    .physical (ptr_phys)
  );

  // write by number or pointer
  addr_translate save_xlate (
    .logical  (save_logical),
    .seg      (seg),
    .physical (save_phys)
  );

  assign register_out = reg_value;
  // stepped value goes out as well as to memory
  assign reg_ptr_out  = save_data;

endmodule

`default_nettype wire

//--- hw/regman_cfg.svh
`ifndef REGMAN_CFG_SVH
`define REGMAN_CFG_SVH

// width of a physical or logical memory address
`define REGMAN_ADDR_W 32

// width of one memory word, i.e. one architectural register
`define REGMAN_DATA_W 32

// register number field in the instruction, 16 registers
`define REGMAN_REG_NUM_W 4

// register manager op code
// must hold every value of reg_op_t
`define REGMAN_OP_W 3

`endif

//--- hw/regman_pkg.sv
`default_nettype none

`include "regman_cfg.svh"

package regman_pkg;

  // op requested by the controller for the current cycle state
  typedef enum logic [`REGMAN_OP_W-1:0] {
    op_idle,
    op_catch,
    op_read,
    op_read_ptr,
    op_write,
    op_write_ptr
  } reg_op_t;

  // post step applied to the value on a write by number
  typedef enum logic [1:0] {
    step_none = 2'b00,
    step_inc  = 2'b01,
    step_dec  = 2'b10
  } step_t;

  // register selection taken from the decoded instruction
  typedef struct packed {
    logic [`REGMAN_REG_NUM_W-1:0] reg_num;
    logic                         is_ptr;
    step_t                        step;
  } reg_sel_t;

  // segment setup of the running process
  typedef struct packed {
    logic [`REGMAN_ADDR_W-1:0] base_addr;
    logic [`REGMAN_ADDR_W-1:0] base_addr_data;
    logic [`REGMAN_ADDR_W-1:0] unmod_bound;
    logic [`REGMAN_ADDR_W-1:0] mem1_size;
  } seg_cfg_t;

  // request side of the memory bus
  typedef struct packed {
    logic                      read_q;
    logic                      write_q;
    logic [`REGMAN_ADDR_W-1:0] addr;
    logic [`REGMAN_DATA_W-1:0] data;
  } bus_req_t;

  // response side of the memory bus
  typedef struct packed {
    logic                      busy;
    logic                      read_dn;
    logic                      write_dn;
    logic [`REGMAN_ADDR_W-1:0] addr;
    logic [`REGMAN_DATA_W-1:0] data;
  } bus_rsp_t;

  // load strobes and values from the sequencer into the value path
  typedef struct packed {
    logic                      load_reg;
    logic                      load_ptr;
    logic                      mark_read;
    logic                      mark_read_ptr;
    logic [`REGMAN_DATA_W-1:0] reg_value;
    logic [`REGMAN_DATA_W-1:0] ptr_value;
  } reg_load_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+hw
hw/regman_pkg.sv
hw/addr_translate.sv
hw/reg_value_path.sv
hw/bus_sequencer.sv
hw/register_manager.sv
verif/tb_mem_model.sv
verif/tb_register_manager.sv

//--- verif/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module tb_mem_model (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire regman_pkg::bus_req_t      req,
  input  wire logic [`REGMAN_DATA_W-1:0] fill_salt,
  output regman_pkg::bus_rsp_t           rsp
);

  // written words, unwritten ones read the fill pattern
  logic [`REGMAN_DATA_W-1:0] mem_arr [logic [`REGMAN_ADDR_W-1:0]];

  function automatic logic [`REGMAN_DATA_W-1:0] word_at(input logic [`REGMAN_ADDR_W-1:0] addr);
    if (mem_arr.exists(addr))
      return mem_arr[addr];
    // every address bit feeds the pattern
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ fill_salt;
  endfunction

  initial begin
    logic [`REGMAN_ADDR_W-1:0] addr;
    logic [`REGMAN_DATA_W-1:0] wdata;
    logic                      is_write;
    int unsigned               delay;
    rsp = '0;
    forever begin
      // strobe sampled mid cycle
      @(negedge clk);
      if (!rst && (req.read_q || req.write_q)) begin
        addr     = req.addr;
        wdata    = req.data;
        is_write = req.write_q;
        @(posedge clk);
        #1;
        rsp.busy = 1'b1;
        // random latency, busy held the whole time
        delay = $urandom_range(1, 8);
        repeat (delay) @(posedge clk);
        #1;
        if (is_write) begin
          mem_arr[addr] = wdata;
          rsp.write_dn  = 1'b1;
        end else begin
          rsp.read_dn = 1'b1;
          rsp.data    = word_at(addr);
        end
        rsp.addr = addr;
        // done lasts one cycle, then bus idle
        @(posedge clk);
        #1;
        rsp = '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_register_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "regman_cfg.svh"

module tb_register_manager;

  logic                      clk;
  logic                      rst;
  regman_pkg::reg_op_t       op;
  regman_pkg::reg_sel_t      sel;
  regman_pkg::seg_cfg_t      seg;
  logic                      alu_result;
  logic                      online;
  logic [`REGMAN_DATA_W-1:0] register_in;
  logic [`REGMAN_DATA_W-1:0] reg_ptr_in;
  regman_pkg::bus_rsp_t      rsp;
  regman_pkg::bus_req_t      req;
  logic [`REGMAN_DATA_W-1:0] register_out;
  logic [`REGMAN_DATA_W-1:0] reg_ptr_out;
  logic                      is_read;
  logic                      is_read_ptr;
  logic                      next_state;
  logic [`REGMAN_DATA_W-1:0] fill_salt;

  // expected copies and the request in flight
  logic [31:0] m_reg;
  logic [31:0] m_ptr;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  logic        exp_write;
  int          strobe_count;

  register_manager uut (.*);

  tb_mem_model mem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // segment rule over shared area, data segment and process segment
  function automatic logic [31:0] exp_xlate(input logic [31:0] a, input regman_pkg::seg_cfg_t s);
    if (a >= s.unmod_bound)
      return a;
    if (a >= s.mem1_size)
      return a + s.base_addr_data;
    return a + s.base_addr;
  endfunction

  function automatic logic [31:0] exp_save_data(input regman_pkg::reg_op_t o,
                                                input regman_pkg::reg_sel_t s);
    logic [31:0] v;
    // register copy when write kind matches register kind
    v = (s.is_ptr == (o == regman_pkg::op_write_ptr)) ? m_reg : m_ptr;
    if (o == regman_pkg::op_write_ptr)
      return v;
    if (s.step == regman_pkg::step_inc)
      return v + 1;
    if (s.step == regman_pkg::step_dec)
      return v - 1;
    return v;
  endfunction

  function automatic logic [31:0] exp_save_addr(input regman_pkg::reg_op_t o,
                                                input regman_pkg::reg_sel_t s);
    return exp_xlate((o == regman_pkg::op_write_ptr) ? m_ptr : 32'(s.reg_num), seg);
  endfunction

  function automatic regman_pkg::reg_sel_t make_sel(input int num, input logic p,
                                                    input regman_pkg::step_t st);
    regman_pkg::reg_sel_t s;
    s.reg_num = num[`REGMAN_REG_NUM_W-1:0];
    s.is_ptr  = p;
    s.step    = st;
    return s;
  endfunction

  task automatic next_drive();
    @(posedge clk);
    #1;
  endtask

  // with idle op and cleared sel reg_ptr_out shows the pointer copy
  task automatic check_copies();
    next_drive();
    op  = regman_pkg::op_idle;
    sel = '0;
    @(negedge clk);
    check_val("register_out", register_out, m_reg);
    check_val("reg_ptr_out", reg_ptr_out, m_ptr);
  endtask

  task automatic do_catch(input logic alu, input logic [31:0] r_in, input logic [31:0] p_in);
    next_drive();
    op          = regman_pkg::op_catch;
    alu_result  = alu;
    register_in = r_in;
    reg_ptr_in  = p_in;
    @(negedge clk);
    check_val("next_state", 32'(next_state), 1);
    // new inputs later in the op must be ignored
    next_drive();
    register_in = ~r_in;
    reg_ptr_in  = ~p_in;
    repeat (2) begin
      @(negedge clk);
      check_val("next_state", 32'(next_state), 1);
    end
    m_reg = alu ? r_in : p_in;
    if (!alu)
      m_ptr = p_in;
    check_copies();
    check_val("is_read", 32'(is_read), 1);
  endtask

  task automatic run_bus_op(input regman_pkg::reg_op_t o, input regman_pkg::reg_sel_t s);
    int   n;
    logic was_done;
    exp_write = (o == regman_pkg::op_write) || (o == regman_pkg::op_write_ptr);
    // read by number bypasses the segment rule
    if (o == regman_pkg::op_read)
      exp_addr = seg.base_addr + 32'(s.reg_num);
    else if (o == regman_pkg::op_read_ptr)
      exp_addr = exp_xlate(m_ptr, seg);
    else
      exp_addr = exp_save_addr(o, s);
    exp_data = exp_save_data(o, s);
    // one offline cycle arms the single request
    next_drive();
    online       = 1'b0;
    strobe_count = 0;
    next_drive();
    op     = o;
    sel    = s;
    online = 1'b1;
    n        = 0;
    was_done = 1'b0;
    @(negedge clk);
    while (!next_state && n < 200) begin
      n++;
      // matching done seen in the cycle before completion
      was_done = rsp.busy && (rsp.read_dn || rsp.write_dn) && (rsp.addr == exp_addr);
      @(negedge clk);
    end
    if (!next_state) begin
      $display("timeout, bus op never completed");
      stop_run();
    end
    assert (was_done) else begin
      $display("next_state did not come one cycle after the matching done");
      stop_run();
    end
    if (exp_write) begin
      check_val("reg_ptr_out", reg_ptr_out, exp_data);
      check_val("memory word", mem.word_at(exp_addr), exp_data);
    end else begin
      m_reg = mem.word_at(exp_addr);
      if (o == regman_pkg::op_read)
        m_ptr = m_reg;
      check_val("register_out", register_out, m_reg);
    end
    // completion is a single-cycle pulse
    @(negedge clk);
    check_val("next_state", 32'(next_state), 0);
    // op still held and no second request allowed
    repeat (4) @(posedge clk);
    check_val("strobe_count", strobe_count, 1);
    check_copies();
  endtask

  // bus watcher sampled mid cycle
  always @(negedge clk) begin
    if (!rst && !online) begin
      assert (req === '0) else begin
        $display("error req got %h expected %h", req, 0);
        stop_run();
      end
    end
    if (!rst && (req.read_q || req.write_q)) begin
      strobe_count = strobe_count + 1;
      check_val("req.read_q", 32'(req.read_q), 32'(!exp_write));
      check_val("req.write_q", 32'(req.write_q), 32'(exp_write));
      check_val("req.addr", req.addr, exp_addr);
      if (req.write_q)
        check_val("req.data", req.data, exp_data);
    end
  end

  initial begin
    regman_pkg::step_t steps [3];
    logic [31:0]       ptrs [3];
    void'($urandom(32'h9b83_0cf5));
    steps        = '{regman_pkg::step_none, regman_pkg::step_inc, regman_pkg::step_dec};
    fill_salt    = $urandom;
    rst          = 1'b1;
    op           = regman_pkg::op_idle;
    sel          = '0;
    // code below 0x1000 with data up to 0x8000 and shared above
    seg          = '{base_addr: 32'h0001_0000, base_addr_data: 32'h0004_0000,
                     unmod_bound: 32'h0000_8000, mem1_size: 32'h0000_1000};
    alu_result   = 1'b0;
    online       = 1'b0;
    register_in  = '0;
    reg_ptr_in   = '0;
    m_reg        = '0;
    m_ptr        = '0;
    exp_addr     = '0;
    exp_data     = '0;
    exp_write    = 1'b0;
    strobe_count = 0;
    ptrs[0]      = $urandom_range(0, 32'h0fff);
    ptrs[1]      = $urandom_range(32'h1000, 32'h7fff);
    ptrs[2]      = $urandom_range(32'h8000, 32'hffff_ffff);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_val("next_state", 32'(next_state), 0);
    check_val("is_read", 32'(is_read), 0);
    check_copies();
    // a bus op must stay silent while offline
    next_drive();
    op = regman_pkg::op_read;
    repeat (20) @(posedge clk);
    check_val("strobe_count", strobe_count, 0);
    check_copies();
    do_catch(1'b1, $urandom, $urandom);
    check_val("is_read_ptr", 32'(is_read_ptr), 0);
    do_catch(1'b0, $urandom, $urandom);
    check_val("is_read_ptr", 32'(is_read_ptr), 1);
    for (int i = 0; i < 4; i++)
      run_bus_op(regman_pkg::op_read, make_sel(i * 5, 1'b0, regman_pkg::step_none));
    // one pointer in each segment
    for (int i = 0; i < 3; i++) begin
      do_catch(1'b0, $urandom, ptrs[i]);
      run_bus_op(regman_pkg::op_read_ptr, make_sel(0, 1'b0, regman_pkg::step_none));
    end
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 3; k++) begin
        do_catch(1'b1, $urandom, $urandom);
        run_bus_op(regman_pkg::op_write, make_sel($urandom_range(0, 15), p[0], steps[k]));
      end
    end
    // step is ignored under write through pointer
    repeat (8) begin
      do_catch(1'b0, $urandom, ptrs[$urandom_range(0, 2)]);
      do_catch(1'b1, $urandom, $urandom);
      run_bus_op(regman_pkg::op_write_ptr,
                 make_sel($urandom_range(0, 15), 1'b1, steps[$urandom_range(0, 2)]));
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
